/* rv_exec_cfg.svh */
`ifndef RV_EXEC_CFG_SVH
`define RV_EXEC_CFG_SVH

// Datapath width and register file depth
`define RV_XLEN             32
`define RV_NUM_REGS         32
`define RV_REG_AW           $clog2(`RV_NUM_REGS)

// APB slave address width
`define RV_APB_ADDR_W       8

// Address map, byte addresses on word boundaries
`define RV_ADDR_INSTR       8'h00    // Write only, starts execution
`define RV_ADDR_LOAD_DATA   8'h04    // Data returned by LOAD
`define RV_ADDR_PC          8'h08    // Read only
`define RV_ADDR_STATUS      8'h0C    // Bit 0 illegal (sticky), bit 1 busy
`define RV_ADDR_REG_BASE    8'h80    // x0 to x31 at a stride of 4

// Status word bit positions
`define RV_STAT_ILLEGAL     0
`define RV_STAT_BUSY        1

`endif

/* rv_exec_pkg.sv */
`include "rv_exec_cfg.svh"

package rv_exec_pkg;

    // Major opcodes, RV32I encodings
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B    // LUI passes the immediate through
    } alu_op_e;

    // Write-back source, same codes as the register file input mux
    typedef enum logic [1:0] {
        WB_NONE = 2'b00,
        WB_MEM  = 2'b01,
        WB_PC   = 2'b10,    // Link value pc + 4
        WB_ALU  = 2'b11
    } wb_sel_e;

    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_EXEC = 1'b1
    } seq_state_e;

    typedef struct packed {
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   imm;
        logic                  use_imm;
        alu_op_e               alu_op;
        wb_sel_e               wb_sel;
        logic                  is_jal;
        logic                  illegal;
    } dec_ctrl_t;

    typedef struct packed {
        logic                  en;
        logic [`RV_REG_AW-1:0] rd;
        wb_sel_e               wb_sel;
        logic [`RV_XLEN-1:0]   mem_data;
        logic [`RV_XLEN-1:0]   pc_link;
        logic [`RV_XLEN-1:0]   alu_result;
    } rf_write_t;

    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [`RV_APB_ADDR_W-1:0] paddr;
        logic [`RV_XLEN-1:0]       pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] prdata;
        logic                pready;
        logic                pslverr;
    } apb_rsp_t;

endpackage

/* register_file.sv */
`timescale 1ns/10ps
`include "rv_exec_cfg.svh"

module register_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`RV_REG_AW-1:0]  raddr1,
    input  logic [`RV_REG_AW-1:0]  raddr2,
    input  rv_exec_pkg::rf_write_t wr,
    output logic [`RV_XLEN-1:0]    rdata1,
    output logic [`RV_XLEN-1:0]    rdata2
);
    import rv_exec_pkg::*;

    logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];    // No storage behind x0
    logic [`RV_XLEN-1:0] wdata;

    // Write data source
    always_comb begin : select_wdata
        case (wr.wb_sel)
            WB_MEM:  wdata = wr.mem_data;
            WB_PC:   wdata = wr.pc_link;
            WB_ALU:  wdata = wr.alu_result;
            default: wdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && wr.rd != '0) begin    // Writes to x0 are dropped
            regs[wr.rd] <= wdata;
        end
    end

    // Combinational reads, x0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* alu.sv */
`timescale 1ns/10ps
`include "rv_exec_cfg.svh"

module alu (
    input  rv_exec_pkg::alu_op_e op,
    input  logic [`RV_XLEN-1:0]  a,
    input  logic [`RV_XLEN-1:0]  b,
    output logic [`RV_XLEN-1:0]  result
);
    import rv_exec_pkg::*;

    logic [4:0]          shamt;
    logic                lt_signed;
    logic                lt_unsigned;
    logic [`RV_XLEN-1:0] sum;
    logic [`RV_XLEN-1:0] diff;

    assign shamt       = b[4:0];    // Only the low 5 bits shift
    assign sum         = a + b;
    assign diff        = a - b;
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:    result = sum;
            ALU_SUB:    result = diff;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLL:    result = a << shamt;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $signed(a) >>> shamt;
            ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

/* instr_decoder.sv */
`timescale 1ns/10ps
`include "rv_exec_cfg.svh"

module instr_decoder (
    input  logic [`RV_XLEN-1:0]    instr,
    output rv_exec_pkg::dec_ctrl_t ctrl
);
    import rv_exec_pkg::*;

    opcode_e             opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    // Shared by OP and OP-IMM, alt picks sub or sra
    function automatic alu_op_e f3_alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  f3_alu_op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  f3_alu_op = ALU_SLL;
            3'b010:  f3_alu_op = ALU_SLT;
            3'b011:  f3_alu_op = ALU_SLTU;
            3'b100:  f3_alu_op = ALU_XOR;
            3'b101:  f3_alu_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  f3_alu_op = ALU_OR;
            default: f3_alu_op = ALU_AND;
        endcase
    endfunction

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Immediate formats
    assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl         = '0;
        ctrl.rs1     = instr[19:15];
        ctrl.rs2     = instr[24:20];
        ctrl.rd      = instr[11:7];
        ctrl.imm     = imm_i;
        ctrl.alu_op  = ALU_ADD;
        ctrl.wb_sel  = WB_NONE;

        case (opcode)
            OPC_OP: begin
                ctrl.alu_op = f3_alu_op(funct3, funct7[5]);
                ctrl.wb_sel = WB_ALU;
                if (funct7 == 7'h20) begin
                    ctrl.illegal = !(funct3 == 3'b000 || funct3 == 3'b101);    // Only sub, sra
                end else begin
                    ctrl.illegal = (funct7 != 7'h00);
                end
            end
            OPC_OP_IMM: begin
                ctrl.use_imm = 1'b1;
                ctrl.alu_op  = f3_alu_op(funct3, funct3 == 3'b101 && funct7[5]);
                ctrl.wb_sel  = WB_ALU;
                if (funct3 == 3'b001) begin
                    ctrl.illegal = (funct7 != 7'h00);    // slli
                end else if (funct3 == 3'b101) begin
                    ctrl.illegal = !(funct7 == 7'h00 || funct7 == 7'h20);
                end
            end
            OPC_LUI: begin
                ctrl.imm     = imm_u;
                ctrl.use_imm = 1'b1;
                ctrl.alu_op  = ALU_PASS_B;
                ctrl.wb_sel  = WB_ALU;
            end
            OPC_LOAD: begin
                ctrl.use_imm = 1'b1;    // Address unused, data from load register
                ctrl.wb_sel  = WB_MEM;
            end
            OPC_JAL: begin
                ctrl.imm    = imm_j;
                ctrl.is_jal = 1'b1;
                ctrl.wb_sel = WB_PC;
            end
            default: ctrl.illegal = 1'b1;
        endcase

        if (ctrl.illegal) begin
            ctrl.wb_sel = WB_NONE;
            ctrl.is_jal = 1'b0;
        end
    end

endmodule

/* exec_apb_port.sv */
`timescale 1ns/10ps
`include "rv_exec_cfg.svh"

module exec_apb_port (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_exec_pkg::apb_req_t  apb_req,
    output rv_exec_pkg::apb_rsp_t  apb_rsp,
    output logic [`RV_XLEN-1:0]    instr,
    input  rv_exec_pkg::dec_ctrl_t ctrl,
    output logic [`RV_REG_AW-1:0]  raddr1,
    output logic [`RV_REG_AW-1:0]  raddr2,
    input  logic [`RV_XLEN-1:0]    rdata1,
    input  logic [`RV_XLEN-1:0]    alu_result,
    output logic                   use_imm_b,
    output rv_exec_pkg::rf_write_t wr
);
    import rv_exec_pkg::*;

    seq_state_e                state;
    logic [`RV_XLEN-1:0]       load_data;
    logic [`RV_XLEN-1:0]       pc;
    logic [`RV_XLEN-1:0]       pc_link;
    logic                      illegal_flag;
    logic                      busy;
    logic                      access;
    logic                      pready;
    logic                      is_reg;
    logic                      rd_ok;
    logic                      wr_ok;
    logic                      host_wr;
    logic [`RV_APB_ADDR_W-1:0] reg_off;
    logic [`RV_XLEN-1:0]       rd_data;

    assign busy    = (state == SEQ_EXEC);
    assign pc_link = pc + `RV_XLEN'(4);

    // Address decode
    assign access  = apb_req.psel && apb_req.penable;
    assign is_reg  = apb_req.paddr >= `RV_ADDR_REG_BASE
                  && apb_req.paddr < `RV_ADDR_REG_BASE + 4 * `RV_NUM_REGS
                  && apb_req.paddr[1:0] == 2'b00;
    assign reg_off = apb_req.paddr - `RV_ADDR_REG_BASE;
    assign wr_ok   = apb_req.paddr == `RV_ADDR_INSTR || apb_req.paddr == `RV_ADDR_LOAD_DATA;

    always_comb begin
        rd_ok   = 1'b1;
        rd_data = '0;
        if (is_reg) begin
            rd_data = rdata1;    // Host read shares port 1
        end else begin
            case (apb_req.paddr)
                `RV_ADDR_LOAD_DATA: rd_data = load_data;
                `RV_ADDR_PC:        rd_data = pc;
                `RV_ADDR_STATUS: begin
                    rd_data[`RV_STAT_ILLEGAL] = illegal_flag;
                    rd_data[`RV_STAT_BUSY]    = busy;
                end
                default:            rd_ok = 1'b0;    // Includes write-only INSTR
            endcase
        end
    end

    // One wait state for any access that lands in the EXEC cycle
    assign pready  = access && !busy;
    assign host_wr = pready && apb_req.pwrite && wr_ok;

    assign apb_rsp.prdata  = rd_data;
    assign apb_rsp.pready  = pready;
    assign apb_rsp.pslverr = pready && (apb_req.pwrite ? !wr_ok : !rd_ok);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= SEQ_IDLE;
            instr        <= '0;
            load_data    <= '0;
            pc           <= '0;
            illegal_flag <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (host_wr && apb_req.paddr == `RV_ADDR_INSTR) begin
                        instr <= apb_req.pwdata;
                        state <= SEQ_EXEC;
                    end
                    if (host_wr && apb_req.paddr == `RV_ADDR_LOAD_DATA) begin
                        load_data <= apb_req.pwdata;
                    end
                end
                SEQ_EXEC: begin
                    state <= SEQ_IDLE;
                    if (ctrl.illegal) begin
                        illegal_flag <= 1'b1;    // Sticky, PC holds
                    end else if (ctrl.is_jal) begin
                        pc <= pc + ctrl.imm;
                    end else begin
                        pc <= pc_link;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Register file read ports
    assign raddr1    = busy ? ctrl.rs1 : reg_off[`RV_REG_AW+1:2];
    assign raddr2    = ctrl.rs2;
    assign use_imm_b = ctrl.use_imm;

    // Write-back request, taken at the end of EXEC
    assign wr.en         = busy && !ctrl.illegal && ctrl.wb_sel != WB_NONE && ctrl.rd != '0;
    assign wr.rd         = ctrl.rd;
    assign wr.wb_sel     = ctrl.wb_sel;
    assign wr.mem_data   = load_data;
    assign wr.pc_link    = pc_link;
    assign wr.alu_result = alu_result;

endmodule

/* rv_exec_top.sv */
`timescale 1ns/10ps
`include "rv_exec_cfg.svh"

module rv_exec_top (
    input  logic                  clk,
    input  logic                  rst,
    input  rv_exec_pkg::apb_req_t apb_req,
    output rv_exec_pkg::apb_rsp_t apb_rsp
);
    import rv_exec_pkg::*;

    logic [`RV_XLEN-1:0]   instr;
    dec_ctrl_t             ctrl;
    logic [`RV_REG_AW-1:0] raddr1;
    logic [`RV_REG_AW-1:0] raddr2;
    logic [`RV_XLEN-1:0]   rdata1;
    logic [`RV_XLEN-1:0]   rdata2;
    logic [`RV_XLEN-1:0]   alu_b;
    logic [`RV_XLEN-1:0]   alu_result;
    logic                  use_imm_b;
    rf_write_t             wr;

    exec_apb_port u_port (
        .clk        (clk),
        .rst        (rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .instr      (instr),
        .ctrl       (ctrl),
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .rdata1     (rdata1),
        .alu_result (alu_result),
        .use_imm_b  (use_imm_b),
        .wr         (wr)
    );

    instr_decoder u_dec (
        .instr (instr),
        .ctrl  (ctrl)
    );

    register_file u_rf (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .wr     (wr),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    // Operand B is the immediate for OP-IMM, LUI and LOAD
    assign alu_b = use_imm_b ? ctrl.imm : rdata2;

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (rdata1),
        .b      (alu_b),
        .result (alu_result)
    );

endmodule

/* tb_rv_exec.sv */
`timescale 1ns/10ps
`include "rv_exec_cfg.svh"

module tb_rv_exec;
    import rv_exec_pkg::*;

    localparam logic [31:0] LFSR_MASK = 32'h8020_0003;
    localparam int NUM_ARITH      = 40;
    localparam int NUM_XFERS      = 34 + 6 * (`RV_NUM_REGS - 1) + 3 * NUM_ARITH + 40;
    localparam int TIMEOUT_CYCLES = 4 * NUM_XFERS + 200;

    // {funct7, funct3} for add sub sll slt sltu xor srl sra or and
    localparam logic [9:0] OP_FUNCT [0:9] = '{10'h000, 10'h100, 10'h001, 10'h002, 10'h003,
                                              10'h004, 10'h005, 10'h105, 10'h006, 10'h007};

    logic        clk = 1'b0;
    logic        rst;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [31:0] lfsr_state = 32'd29;
    logic [31:0] model_regs [0:31];
    logic [31:0] model_pc;
    int          cycles = 0;

    rv_exec_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a transfer never completed", cycles);
            $display("*** TEST FAILED ***");
            $fatal(1, "Timeout");
        end
    end

    // pready and pslverr only inside an access phase
    always @(negedge clk) begin
        if (!rst) begin
            assert (!apb_rsp.pready || (apb_req.psel && apb_req.penable))
                else report_failure("pready was high outside an access phase");
            assert (!apb_rsp.pslverr || apb_rsp.pready)
                else report_failure("pslverr was high without pready");
        end
    end

    task automatic report_failure(input string msg);
        $display("Protocol error: %s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", msg);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED %s: expected %h, actual %h", name, exp, act);
        $display("*** TEST FAILED ***");
        $fatal(1, "Mismatch in %s", name);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else report_mismatch(name, exp, act);
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        out;
        val = '0;
        for (int i = 0; i < n; i++) begin
            out        = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (out ? LFSR_MASK : 32'h0);
            val        = {val[30:0], out};
        end
        return val;
    endfunction

    function automatic logic [31:0] expected_alu(input int k, input logic [31:0] a,
                                                 input logic [31:0] b);
        case (k)
            0:       return a + b;
            1:       return a - b;
            2:       return a << b[4:0];
            3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4:       return (a < b) ? 32'd1 : 32'd0;
            5:       return a ^ b;
            6:       return a >> b[4:0];
            7:       return $signed(a) >>> b[4:0];
            8:       return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [7:0] reg_addr(input logic [4:0] r);
        return `RV_ADDR_REG_BASE + {r, 2'b00};
    endfunction

    task automatic start_setup(input logic write, input logic [7:0] addr,
                               input logic [31:0] data);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= data;
        @(posedge clk);
        apb_req.penable <= 1'b1;
    endtask

    // New access straight from the completion edge lands in the EXEC cycle
    task automatic chain_access(input logic write, input logic [7:0] addr,
                                input logic [31:0] data);
        apb_req.pwrite <= write;
        apb_req.paddr  <= addr;
        apb_req.pwdata <= data;
    endtask

    task automatic wait_complete(output logic [31:0] rdata, output logic err,
                                 output int waits);
        waits = 0;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            waits++;
            @(negedge clk);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);    // Completion edge
    endtask

    task automatic bus_idle();
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic apb_xfer(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        int waits;
        start_setup(write, addr, wdata);
        wait_complete(rdata, err, waits);
        bus_idle();
        check_value($sformatf("wait states at %h", addr), 32'd0, 32'(waits));
    endtask

    task automatic read_check(input string name, input logic [7:0] addr,
                              input logic [31:0] exp);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        check_value({name, " pslverr"}, 32'd0, {31'd0, err});
        check_value(name, exp, rdata);
    endtask

    task automatic expect_error(input string name, input logic write, input logic [7:0] addr);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(write, addr, 32'hFFFF_FFFF, rdata, err);
        check_value({name, " pslverr"}, 32'd1, {31'd0, err});
    endtask

    // Execute one instruction, then read back rd and the PC
    task automatic run_and_check(input string name, input logic [31:0] instr,
                                 input logic [4:0] rd, input logic [31:0] result,
                                 input logic [31:0] next_pc);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, `RV_ADDR_INSTR, instr, rdata, err);
        check_value({name, " pslverr"}, 32'd0, {31'd0, err});
        if (rd != 5'd0) begin
            model_regs[rd] = result;
        end
        model_pc = next_pc;
        read_check({name, " rd"}, reg_addr(rd), model_regs[rd]);
        read_check({name, " pc"}, `RV_ADDR_PC, model_pc);
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        int          waits;
        int          k;
        logic        use_imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] instr;
        logic [31:0] load_val;
        logic [31:0] jal_imm;

        rst      = 1'b1;
        apb_req  = '0;
        model_pc = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (int r = 0; r < 32; r++) begin
            read_check($sformatf("reset x%0d", r), reg_addr(5'(r)), 32'd0);
        end
        read_check("reset pc", `RV_ADDR_PC, 32'd0);
        read_check("reset status", `RV_ADDR_STATUS, 32'd0);

        // LUI then ADDI into every register
        for (int r = 1; r < 32; r++) begin
            imm20 = 20'(rand_bits(20));
            imm12 = 12'(rand_bits(12));
            run_and_check($sformatf("lui x%0d", r), {imm20, 5'(r), 7'b0110111}, 5'(r),
                          {imm20, 12'd0}, model_pc + 4);
            run_and_check($sformatf("addi x%0d", r), {imm12, 5'(r), 3'd0, 5'(r), 7'b0010011},
                          5'(r), model_regs[r] + {{20{imm12[11]}}, imm12}, model_pc + 4);
        end

        for (int i = 0; i < NUM_ARITH; i++) begin
            k       = rand_bits(4) % 10;
            use_imm = 1'(rand_bits(1));
            if (use_imm && k == 1) begin
                k = 0;    // No subtract immediate
            end
            rd  = 5'(rand_bits(5));
            rs1 = 5'(rand_bits(5));
            rs2 = 5'(rand_bits(5));
            a   = model_regs[rs1];
            if (use_imm) begin
                imm12 = (k == 2 || k == 6 || k == 7) ? {OP_FUNCT[k][9:3], rs2}
                                                      : 12'(rand_bits(12));
                b     = {{20{imm12[11]}}, imm12};
                instr = {imm12, rs1, OP_FUNCT[k][2:0], rd, 7'b0010011};
            end else begin
                b     = model_regs[rs2];
                instr = {OP_FUNCT[k][9:3], rs2, rs1, OP_FUNCT[k][2:0], rd, 7'b0110011};
            end
            run_and_check($sformatf("arith %0d op %0d imm %0b", i, k, use_imm), instr, rd,
                          expected_alu(k, a, b), model_pc + 4);
        end
        run_and_check("addi x0", {12'h123, 5'd1, 3'd0, 5'd0, 7'b0010011}, 5'd0, 32'd0,
                      model_pc + 4);

        // LOAD takes the load-data register whatever its funct3
        load_val = rand_bits(32);
        apb_xfer(1'b1, `RV_ADDR_LOAD_DATA, load_val, rdata, err);
        check_value("load data pslverr", 32'd0, {31'd0, err});
        read_check("load data readback", `RV_ADDR_LOAD_DATA, load_val);
        rd    = 5'(rand_bits(5)) | 5'd1;
        imm12 = 12'(rand_bits(12));
        instr = {imm12, 5'(rand_bits(5)), 3'(rand_bits(3)), rd, 7'b0000011};
        run_and_check("load", instr, rd, load_val, model_pc + 4);

        rd      = 5'(rand_bits(5)) | 5'd1;
        imm20   = 20'(rand_bits(20));
        jal_imm = {{11{imm20[19]}}, imm20, 1'b0};
        instr   = {jal_imm[20], jal_imm[10:1], jal_imm[11], jal_imm[19:12], rd, 7'b1101111};
        run_and_check("jal", instr, rd, model_pc + 4, model_pc + jal_imm);

        // XORI then ADDI back to back, then a read in the EXEC cycle
        rd    = 5'(rand_bits(5)) | 5'd1;
        rs1   = 5'(rand_bits(5));
        imm12 = 12'(rand_bits(12));
        start_setup(1'b1, `RV_ADDR_INSTR, {imm12, rs1, 3'd4, rd, 7'b0010011});
        wait_complete(rdata, err, waits);
        check_value("back-pressure first write waits", 32'd0, 32'(waits));
        check_value("back-pressure first write pslverr", 32'd0, {31'd0, err});
        model_regs[rd] = model_regs[rs1] ^ {{20{imm12[11]}}, imm12};
        model_pc       = model_pc + 4;
        chain_access(1'b1, `RV_ADDR_INSTR, {imm12, rd, 3'd0, rd, 7'b0010011});
        wait_complete(rdata, err, waits);
        check_value("back-pressure write waits", 32'd1, 32'(waits));
        check_value("back-pressure write pslverr", 32'd0, {31'd0, err});
        model_regs[rd] = model_regs[rd] + {{20{imm12[11]}}, imm12};
        model_pc       = model_pc + 4;
        chain_access(1'b0, reg_addr(rd), 32'd0);
        wait_complete(rdata, err, waits);
        bus_idle();
        check_value("back-pressure read waits", 32'd1, 32'(waits));
        check_value("back-pressure read pslverr", 32'd0, {31'd0, err});
        check_value("back-pressure read data", model_regs[rd], rdata);
        read_check("back-pressure pc", `RV_ADDR_PC, model_pc);

        // Opcode 0x7F with rd = x5
        apb_xfer(1'b1, `RV_ADDR_INSTR, 32'h0000_02FF, rdata, err);
        check_value("illegal pslverr", 32'd0, {31'd0, err});
        read_check("illegal status", `RV_ADDR_STATUS, 32'd1);
        read_check("illegal pc", `RV_ADDR_PC, model_pc);
        read_check("illegal x5", reg_addr(5'd5), model_regs[5]);
        expect_error("write pc", 1'b1, `RV_ADDR_PC);
        read_check("pc after write", `RV_ADDR_PC, model_pc);
        expect_error("write status", 1'b1, `RV_ADDR_STATUS);
        read_check("status after write", `RV_ADDR_STATUS, 32'd1);
        expect_error("write x3", 1'b1, reg_addr(5'd3));
        read_check("x3 after write", reg_addr(5'd3), model_regs[3]);
        expect_error("read 0x10", 1'b0, 8'h10);
        expect_error("read 0x40", 1'b0, 8'h40);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
rv_exec_pkg.sv
register_file.sv
alu.sv
instr_decoder.sv
exec_apb_port.sv
rv_exec_top.sv
tb_rv_exec.sv
